/* flight_pkg.sv */
`default_nettype none

package flight_pkg;

	// receiver stick values are unsigned bytes
	parameter int REC_WIDTH = 8;

	// rates, angles and errors are signed q12.4
	// 12 integer bits, 4 fraction bits
	parameter int RATE_WIDTH = 16;

	// a stick value r maps to r*4 in q12.4
	// subtracting 500 (31.25 deg) centres a 0..250 stick around zero
	parameter logic signed [RATE_WIDTH-1:0] STICK_CENTER = 16'sd500;

	// throttle ceiling, 252.0
	// throttle is also floored at zero
	parameter logic signed [RATE_WIDTH-1:0] THROTTLE_MAX = 16'sh0fc0;

	// symmetric yaw, pitch and roll limit, 25.0
	parameter logic signed [RATE_WIDTH-1:0] AXIS_LIMIT = 16'sh0190;

	// controller sequence
	// one working state per cycle, back to WAITING after COMPLETE
	typedef enum logic [2:0] {
		// idle, waits for start
		WAITING  = 3'd0,
		// stick mapping and angle error
		MAPPING  = 3'd1,
		// gain shift on pitch and roll errors
		SCALING  = 3'd2,
		// clamp to the rate limits
		LIMITING = 3'd3,
		// rates stable, done pulse
		COMPLETE = 3'd4
	} ctrl_state_t;

endpackage

`default_nettype wire

/* target_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module target_capture (
	input wire us_clk,
	input wire resetn,
	input wire sample_strobe,
	input wire [flight_pkg::REC_WIDTH-1:0] throttle_target,
	input wire [flight_pkg::REC_WIDTH-1:0] yaw_target,
	input wire [flight_pkg::REC_WIDTH-1:0] pitch_target,
	input wire [flight_pkg::REC_WIDTH-1:0] roll_target,
	input wire [flight_pkg::RATE_WIDTH-1:0] pitch_actual,
	input wire [flight_pkg::RATE_WIDTH-1:0] roll_actual,
	input wire busy,
	output logic [flight_pkg::REC_WIDTH-1:0] held_throttle,
	output logic [flight_pkg::REC_WIDTH-1:0] held_yaw,
	output logic [flight_pkg::REC_WIDTH-1:0] held_pitch,
	output logic [flight_pkg::REC_WIDTH-1:0] held_roll,
	output logic [flight_pkg::RATE_WIDTH-1:0] held_pitch_actual,
	output logic [flight_pkg::RATE_WIDTH-1:0] held_roll_actual,
	output logic start
);

	logic accept;

	// take a strobe only when the controller is idle
	// and no start is still on its way to it
	// anything else is simply dropped
	assign accept = sample_strobe && !busy && !start;

	// start is a single cycle pulse following each accepted strobe
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			start <= 1'b0;
		end else begin
			start <= accept;
		end
	end

	// all six operands are captured together
	// so a late strobe cannot mix old and new values
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			held_throttle <= '0;
			held_yaw <= '0;
			held_pitch <= '0;
			held_roll <= '0;
			held_pitch_actual <= '0;
			held_roll_actual <= '0;
		end else if (accept) begin
			// stick targets from the receiver
			held_throttle <= throttle_target;
			held_yaw <= yaw_target;
			held_pitch <= pitch_target;
			held_roll <= roll_target;
			// measured angles from the imu
			held_pitch_actual <= pitch_actual;
			held_roll_actual <= roll_actual;
		end
	end

endmodule

`default_nettype wire

/* angle_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module angle_controller #(
	parameter int ANGLE_GAIN_SHIFT = 1
) (
	input wire us_clk,
	input wire resetn,
	input wire start,
	input wire [flight_pkg::REC_WIDTH-1:0] held_throttle,
	input wire [flight_pkg::REC_WIDTH-1:0] held_yaw,
	input wire [flight_pkg::REC_WIDTH-1:0] held_pitch,
	input wire [flight_pkg::REC_WIDTH-1:0] held_roll,
	input wire [flight_pkg::RATE_WIDTH-1:0] held_pitch_actual,
	input wire [flight_pkg::RATE_WIDTH-1:0] held_roll_actual,
	output logic [flight_pkg::RATE_WIDTH-1:0] throttle_rate,
	output logic [flight_pkg::RATE_WIDTH-1:0] yaw_rate,
	output logic [flight_pkg::RATE_WIDTH-1:0] pitch_rate,
	output logic [flight_pkg::RATE_WIDTH-1:0] roll_rate,
	output logic [flight_pkg::RATE_WIDTH-1:0] pitch_angle_error,
	output logic [flight_pkg::RATE_WIDTH-1:0] roll_angle_error,
	output logic busy,
	output logic rates_done
);

	localparam int RW = flight_pkg::RATE_WIDTH;
	// zero bits above the stick value once it is shifted up by two
	localparam int PAD = RW - flight_pkg::REC_WIDTH - 2;
	localparam logic signed [RW-1:0] AXIS_MIN = -flight_pkg::AXIS_LIMIT;

	flight_pkg::ctrl_state_t state;
	flight_pkg::ctrl_state_t next_state;

	// mapped values, valid from SCALING on
	logic signed [RW-1:0] mapped_throttle;
	logic signed [RW-1:0] mapped_yaw;
	logic signed [RW-1:0] mapped_pitch;
	logic signed [RW-1:0] mapped_roll;
	// gained values, valid from LIMITING on
	logic signed [RW-1:0] scaled_throttle;
	logic signed [RW-1:0] scaled_yaw;
	logic signed [RW-1:0] scaled_pitch;
	logic signed [RW-1:0] scaled_roll;

	// stick byte times four, as q12.4
	function automatic logic signed [RW-1:0] stick_x4(
		input logic [flight_pkg::REC_WIDTH-1:0] r
	);
		return $signed({{PAD{1'b0}}, r, 2'b00});
	endfunction

	// signed saturation between lo and hi
	function automatic logic signed [RW-1:0] clamp_q(
		input logic signed [RW-1:0] v,
		input logic signed [RW-1:0] lo,
		input logic signed [RW-1:0] hi
	);
		logic signed [RW-1:0] res;
		if (v > hi) begin
			res = hi;
		end else if (v < lo) begin
			res = lo;
		end else begin
			res = v;
		end
		return res;
	endfunction

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= flight_pkg::WAITING;
		end else begin
			state <= next_state;
		end
	end

	// start only matters when idle, the rest is a fixed walk
	always_comb begin
		case (state)
			flight_pkg::WAITING: next_state = start ? flight_pkg::MAPPING : flight_pkg::WAITING;
			flight_pkg::MAPPING: next_state = flight_pkg::SCALING;
			flight_pkg::SCALING: next_state = flight_pkg::LIMITING;
			flight_pkg::LIMITING: next_state = flight_pkg::COMPLETE;
			default: next_state = flight_pkg::WAITING;
		endcase
	end

	// busy covers MAPPING through COMPLETE
	assign busy = (state != flight_pkg::WAITING);
	assign rates_done = (state == flight_pkg::COMPLETE);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			mapped_throttle <= '0;
			mapped_yaw <= '0;
			mapped_pitch <= '0;
			mapped_roll <= '0;
			scaled_throttle <= '0;
			scaled_yaw <= '0;
			scaled_pitch <= '0;
			scaled_roll <= '0;
			throttle_rate <= '0;
			yaw_rate <= '0;
			pitch_rate <= '0;
			roll_rate <= '0;
			pitch_angle_error <= '0;
			roll_angle_error <= '0;
		end else begin
			case (state)
				flight_pkg::MAPPING: begin
					// throttle stays unsigned 0..1020
					mapped_throttle <= stick_x4(held_throttle);
					mapped_yaw <= stick_x4(held_yaw) - flight_pkg::STICK_CENTER;
					// target angle minus measured angle
					mapped_pitch <= stick_x4(held_pitch) - flight_pkg::STICK_CENTER
						- $signed(held_pitch_actual);
					mapped_roll <= stick_x4(held_roll) - flight_pkg::STICK_CENTER
						- $signed(held_roll_actual);
				end
				flight_pkg::SCALING: begin
					scaled_throttle <= mapped_throttle;
					scaled_yaw <= mapped_yaw;
					// power of two gain on the angle errors only
					scaled_pitch <= mapped_pitch <<< ANGLE_GAIN_SHIFT;
					scaled_roll <= mapped_roll <<< ANGLE_GAIN_SHIFT;
				end
				flight_pkg::LIMITING: begin
					throttle_rate <= clamp_q(scaled_throttle, '0, flight_pkg::THROTTLE_MAX);
					yaw_rate <= clamp_q(scaled_yaw, AXIS_MIN, flight_pkg::AXIS_LIMIT);
					pitch_rate <= clamp_q(scaled_pitch, AXIS_MIN, flight_pkg::AXIS_LIMIT);
					roll_rate <= clamp_q(scaled_roll, AXIS_MIN, flight_pkg::AXIS_LIMIT);
					// errors go out before the gain
					pitch_angle_error <= mapped_pitch;
					roll_angle_error <= mapped_roll;
				end
				default: begin
					// WAITING and COMPLETE hold everything
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* motor_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module motor_mixer #(
	parameter int MOTOR_WIDTH = 12
) (
	input wire us_clk,
	input wire resetn,
	input wire rates_done,
	input wire [flight_pkg::RATE_WIDTH-1:0] throttle_rate,
	input wire [flight_pkg::RATE_WIDTH-1:0] yaw_rate,
	input wire [flight_pkg::RATE_WIDTH-1:0] pitch_rate,
	input wire [flight_pkg::RATE_WIDTH-1:0] roll_rate,
	output logic [MOTOR_WIDTH-1:0] motor_front_left,
	output logic [MOTOR_WIDTH-1:0] motor_front_right,
	output logic [MOTOR_WIDTH-1:0] motor_rear_right,
	output logic [MOTOR_WIDTH-1:0] motor_rear_left,
	output logic motors_valid
);

	localparam int RW = flight_pkg::RATE_WIDTH;
	// four terms need two extra bits
	// and the sum must also reach past the motor range
	localparam int SUM_WIDTH = (MOTOR_WIDTH + 1 > RW + 2) ? MOTOR_WIDTH + 1 : RW + 2;
	localparam logic signed [SUM_WIDTH-1:0] MOTOR_MAX =
		$signed({{(SUM_WIDTH - MOTOR_WIDTH){1'b0}}, {MOTOR_WIDTH{1'b1}}});

	// sign extended rates
	logic signed [SUM_WIDTH-1:0] t_ext;
	logic signed [SUM_WIDTH-1:0] y_ext;
	logic signed [SUM_WIDTH-1:0] p_ext;
	logic signed [SUM_WIDTH-1:0] r_ext;
	// raw mix per motor
	logic signed [SUM_WIDTH-1:0] fl_sum;
	logic signed [SUM_WIDTH-1:0] fr_sum;
	logic signed [SUM_WIDTH-1:0] rr_sum;
	logic signed [SUM_WIDTH-1:0] rl_sum;

	// floor at zero, ceiling at full scale
	function automatic logic [MOTOR_WIDTH-1:0] clamp_motor(
		input logic signed [SUM_WIDTH-1:0] s
	);
		logic [MOTOR_WIDTH-1:0] res;
		if (s < 0) begin
			res = '0;
		end else if (s > MOTOR_MAX) begin
			res = MOTOR_MAX[MOTOR_WIDTH-1:0];
		end else begin
			res = s[MOTOR_WIDTH-1:0];
		end
		return res;
	endfunction

	assign t_ext = SUM_WIDTH'($signed(throttle_rate));
	assign y_ext = SUM_WIDTH'($signed(yaw_rate));
	assign p_ext = SUM_WIDTH'($signed(pitch_rate));
	assign r_ext = SUM_WIDTH'($signed(roll_rate));

	// x frame mix
	// pitch up raises the front pair, roll right raises the left pair,
	// yaw splits across the diagonals by spin direction
	assign fl_sum = t_ext + p_ext + r_ext - y_ext;
	assign fr_sum = t_ext + p_ext - r_ext + y_ext;
	assign rr_sum = t_ext - p_ext - r_ext - y_ext;
	assign rl_sum = t_ext - p_ext + r_ext + y_ext;

	// commands load on the done pulse only and hold otherwise
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			motor_front_left <= '0;
			motor_front_right <= '0;
			motor_rear_right <= '0;
			motor_rear_left <= '0;
			motors_valid <= 1'b0;
		end else begin
			motors_valid <= rates_done;
			if (rates_done) begin
				motor_front_left <= clamp_motor(fl_sum);
				motor_front_right <= clamp_motor(fr_sum);
				motor_rear_right <= clamp_motor(rr_sum);
				motor_rear_left <= clamp_motor(rl_sum);
			end
		end
	end

endmodule

`default_nettype wire

/* flight_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module flight_ctrl_top #(
	parameter int ANGLE_GAIN_SHIFT = 1,
	parameter int MOTOR_WIDTH = 12
) (
	input wire us_clk,
	input wire resetn,
	input wire sample_strobe,
	input wire [flight_pkg::REC_WIDTH-1:0] throttle_target,
	input wire [flight_pkg::REC_WIDTH-1:0] yaw_target,
	input wire [flight_pkg::REC_WIDTH-1:0] pitch_target,
	input wire [flight_pkg::REC_WIDTH-1:0] roll_target,
	input wire [flight_pkg::RATE_WIDTH-1:0] pitch_actual,
	input wire [flight_pkg::RATE_WIDTH-1:0] roll_actual,
	output wire busy,
	output wire [flight_pkg::RATE_WIDTH-1:0] throttle_rate,
	output wire [flight_pkg::RATE_WIDTH-1:0] yaw_rate,
	output wire [flight_pkg::RATE_WIDTH-1:0] pitch_rate,
	output wire [flight_pkg::RATE_WIDTH-1:0] roll_rate,
	output wire [flight_pkg::RATE_WIDTH-1:0] pitch_angle_error,
	output wire [flight_pkg::RATE_WIDTH-1:0] roll_angle_error,
	output wire rates_done,
	output wire [MOTOR_WIDTH-1:0] motor_front_left,
	output wire [MOTOR_WIDTH-1:0] motor_front_right,
	output wire [MOTOR_WIDTH-1:0] motor_rear_right,
	output wire [MOTOR_WIDTH-1:0] motor_rear_left,
	output wire motors_valid
);

	// captured operands and the kick for the controller
	wire [flight_pkg::REC_WIDTH-1:0] held_throttle;
	wire [flight_pkg::REC_WIDTH-1:0] held_yaw;
	wire [flight_pkg::REC_WIDTH-1:0] held_pitch;
	wire [flight_pkg::REC_WIDTH-1:0] held_roll;
	wire [flight_pkg::RATE_WIDTH-1:0] held_pitch_actual;
	wire [flight_pkg::RATE_WIDTH-1:0] held_roll_actual;
	wire start;

	// busy from the controller gates the strobe here
	target_capture u_capture (
		.us_clk(us_clk),
		.resetn(resetn),
		.sample_strobe(sample_strobe),
		.throttle_target(throttle_target),
		.yaw_target(yaw_target),
		.pitch_target(pitch_target),
		.roll_target(roll_target),
		.pitch_actual(pitch_actual),
		.roll_actual(roll_actual),
		.busy(busy),
		.held_throttle(held_throttle),
		.held_yaw(held_yaw),
		.held_pitch(held_pitch),
		.held_roll(held_roll),
		.held_pitch_actual(held_pitch_actual),
		.held_roll_actual(held_roll_actual),
		.start(start)
	);

	angle_controller #(
		.ANGLE_GAIN_SHIFT(ANGLE_GAIN_SHIFT)
	) u_ctrl (
		.us_clk(us_clk),
		.resetn(resetn),
		.start(start),
		.held_throttle(held_throttle),
		.held_yaw(held_yaw),
		.held_pitch(held_pitch),
		.held_roll(held_roll),
		.held_pitch_actual(held_pitch_actual),
		.held_roll_actual(held_roll_actual),
		.throttle_rate(throttle_rate),
		.yaw_rate(yaw_rate),
		.pitch_rate(pitch_rate),
		.roll_rate(roll_rate),
		.pitch_angle_error(pitch_angle_error),
		.roll_angle_error(roll_angle_error),
		.busy(busy),
		.rates_done(rates_done)
	);

	// mixer always takes the result, no back-pressure
	motor_mixer #(
		.MOTOR_WIDTH(MOTOR_WIDTH)
	) u_mixer (
		.us_clk(us_clk),
		.resetn(resetn),
		.rates_done(rates_done),
		.throttle_rate(throttle_rate),
		.yaw_rate(yaw_rate),
		.pitch_rate(pitch_rate),
		.roll_rate(roll_rate),
		.motor_front_left(motor_front_left),
		.motor_front_right(motor_front_right),
		.motor_rear_right(motor_rear_right),
		.motor_rear_left(motor_rear_left),
		.motors_valid(motors_valid)
	);

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 4
) (
	output logic us_clk,
	output logic resetn
);

	// free running clock, half period per phase
	initial begin
		us_clk = 1'b0;
		forever #(PERIOD / 2) us_clk = ~us_clk;
	end

	// reset held over the first rising edges, released on a falling edge
	initial begin
		resetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge us_clk);
		@(negedge us_clk);
		resetn = 1'b1;
	end

endmodule

`default_nettype wire

/* flight_ctrl_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module flight_ctrl_properties (
	input wire us_clk,
	input wire resetn,
	input wire [$bits(flight_pkg::ctrl_state_t)-1:0] state,
	input wire start,
	input wire busy,
	input wire rates_done
);

	// done pulse only closes a run that took start four cycles before
	a_done_in_complete: assert property (@(posedge us_clk) disable iff (!resetn)
		rates_done |-> $past(start, 4))
		else $error("rates_done high without start taken four cycles before");

	// working states advance one step per cycle
	a_map_to_scale: assert property (@(posedge us_clk) disable iff (!resetn)
		(state == flight_pkg::MAPPING) |=> (state == flight_pkg::SCALING))
		else $error("MAPPING not followed by SCALING");
	a_scale_to_limit: assert property (@(posedge us_clk) disable iff (!resetn)
		(state == flight_pkg::SCALING) |=> (state == flight_pkg::LIMITING))
		else $error("SCALING not followed by LIMITING");
	a_limit_to_complete: assert property (@(posedge us_clk) disable iff (!resetn)
		(state == flight_pkg::LIMITING) |=> (state == flight_pkg::COMPLETE))
		else $error("LIMITING not followed by COMPLETE");

	// busy rises as soon as the controller takes start
	a_busy_on_start: assert property (@(posedge us_clk) disable iff (!resetn)
		(state == flight_pkg::WAITING && start) |=> busy)
		else $error("busy did not rise after start was taken");

	// and stays up through the working states until the done pulse
	a_busy_while_working: assert property (@(posedge us_clk) disable iff (!resetn)
		(busy && !rates_done) |=> busy)
		else $error("busy low while the controller is working");

	// never two done pulses back to back
	a_single_done: assert property (@(posedge us_clk) disable iff (!resetn)
		rates_done |=> !rates_done)
		else $error("rates_done high on two consecutive cycles");

endmodule

bind angle_controller flight_ctrl_properties u_props (
	.us_clk(us_clk),
	.resetn(resetn),
	.state(state),
	.start(start),
	.busy(busy),
	.rates_done(rates_done)
);

`default_nettype wire

/* flight_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module flight_ctrl_tb;

	localparam int GAIN_SHIFT = 1;
	localparam int MOTOR_WIDTH = 12;
	localparam int NUM_SAMPLES = 40;
	localparam int CLK_PERIOD = 100;
	localparam int RW = flight_pkg::RATE_WIDTH;
	localparam int CW = flight_pkg::REC_WIDTH;

	wire us_clk;
	wire resetn;
	logic sample_strobe;
	logic [CW-1:0] throttle_target;
	logic [CW-1:0] yaw_target;
	logic [CW-1:0] pitch_target;
	logic [CW-1:0] roll_target;
	logic [RW-1:0] pitch_actual;
	logic [RW-1:0] roll_actual;
	wire busy;
	wire rates_done;
	wire motors_valid;
	wire [RW-1:0] throttle_rate;
	wire [RW-1:0] yaw_rate;
	wire [RW-1:0] pitch_rate;
	wire [RW-1:0] roll_rate;
	wire [RW-1:0] pitch_angle_error;
	wire [RW-1:0] roll_angle_error;
	wire [MOTOR_WIDTH-1:0] motor_front_left;
	wire [MOTOR_WIDTH-1:0] motor_front_right;
	wire [MOTOR_WIDTH-1:0] motor_rear_right;
	wire [MOTOR_WIDTH-1:0] motor_rear_left;

	int seed = 36;
	int cycle = 0;
	int test_errors = 0;
	int total_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	// model results, rates in throttle, yaw, pitch, roll order
	int exp_rate[4];
	int exp_err[2];
	// motors in fl, fr, rr, rl order
	int exp_motor[4];

	tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(4)) u_clock (.us_clk(us_clk), .resetn(resetn));

	flight_ctrl_top #(
		.ANGLE_GAIN_SHIFT(GAIN_SHIFT),
		.MOTOR_WIDTH(MOTOR_WIDTH)
	) uut (
		.us_clk(us_clk), .resetn(resetn), .sample_strobe(sample_strobe),
		.throttle_target(throttle_target), .yaw_target(yaw_target),
		.pitch_target(pitch_target), .roll_target(roll_target),
		.pitch_actual(pitch_actual), .roll_actual(roll_actual), .busy(busy),
		.throttle_rate(throttle_rate), .yaw_rate(yaw_rate),
		.pitch_rate(pitch_rate), .roll_rate(roll_rate),
		.pitch_angle_error(pitch_angle_error), .roll_angle_error(roll_angle_error),
		.rates_done(rates_done), .motor_front_left(motor_front_left),
		.motor_front_right(motor_front_right), .motor_rear_right(motor_rear_right),
		.motor_rear_left(motor_rear_left), .motors_valid(motors_valid)
	);

	// rising edge count, read only on falling edges
	always @(posedge us_clk) cycle = cycle + 1;

	function automatic int clamp(input int v, input int lo, input int hi);
		return (v > hi) ? hi : ((v < lo) ? lo : v);
	endfunction

	task automatic check_value(input string name, input int exp, input int act);
		assert (exp == act) else begin
			$display("Error: %s expected %h, got %h", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond) else begin
			$display("%s", what);
			test_errors++;
		end
	endtask

	// fresh operands, angles over about +-64 deg so the axis clamps are hit
	task automatic randomize_inputs(input bit strobe);
		sample_strobe = strobe;
		throttle_target = CW'($random(seed));
		yaw_target = CW'($random(seed));
		pitch_target = CW'($random(seed));
		roll_target = CW'($random(seed));
		pitch_actual = RW'($random(seed) % 1025);
		roll_actual = RW'($random(seed) % 1025);
	endtask

	// stick map, gain, clamps and x frame mix on the current inputs
	task automatic predict;
		int c;
		int lim;
		int mmax;
		int t;
		int y;
		int p;
		int r;
		c = int'(flight_pkg::STICK_CENTER);
		lim = int'(flight_pkg::AXIS_LIMIT);
		mmax = (1 << MOTOR_WIDTH) - 1;
		exp_err[0] = int'(pitch_target) * 4 - c - int'($signed(pitch_actual));
		exp_err[1] = int'(roll_target) * 4 - c - int'($signed(roll_actual));
		t = clamp(int'(throttle_target) * 4, 0, int'(flight_pkg::THROTTLE_MAX));
		y = clamp(int'(yaw_target) * 4 - c, -lim, lim);
		p = clamp(exp_err[0] * (2 ** GAIN_SHIFT), -lim, lim);
		r = clamp(exp_err[1] * (2 ** GAIN_SHIFT), -lim, lim);
		exp_rate[0] = t;
		exp_rate[1] = y;
		exp_rate[2] = p;
		exp_rate[3] = r;
		exp_motor[0] = clamp(t + p + r - y, 0, mmax);
		exp_motor[1] = clamp(t + p - r + y, 0, mmax);
		exp_motor[2] = clamp(t - p - r - y, 0, mmax);
		exp_motor[3] = clamp(t - p + r + y, 0, mmax);
	endtask

	task automatic check_motors(input int fl, input int fr, input int rr, input int rl);
		check_value("motor_front_left", fl, int'(motor_front_left));
		check_value("motor_front_right", fr, int'(motor_front_right));
		check_value("motor_rear_right", rr, int'(motor_rear_right));
		check_value("motor_rear_left", rl, int'(motor_rear_left));
	endtask

	task automatic report_test(input string name);
		if (test_errors == 0) begin
			tests_passed++;
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, test_errors);
		end
		total_errors += test_errors;
		test_errors = 0;
	endtask

	// one accepted strobe, dropped strobes behind it, then one idle cycle
	task automatic run_sample(input int idx);
		int prev[4];
		int strobe_edge;
		int done_edge;
		int valid_edge;
		bit seen_valid;
		prev[0] = int'(motor_front_left);
		prev[1] = int'(motor_front_right);
		prev[2] = int'(motor_rear_right);
		prev[3] = int'(motor_rear_left);
		@(negedge us_clk);
		randomize_inputs(1'b1);
		predict();
		strobe_edge = cycle + 1;
		done_edge = -1;
		valid_edge = -1;
		seen_valid = 1'b0;
		while (!seen_valid) begin
			@(negedge us_clk);
			// busy from the edge after the strobe up to the done pulse
			check_value("busy", (cycle > strobe_edge && cycle < strobe_edge + 5) ? 1 : 0,
				int'(busy));
			if (rates_done) begin
				done_edge = cycle;
				check_value("throttle_rate", exp_rate[0], int'($signed(throttle_rate)));
				check_value("yaw_rate", exp_rate[1], int'($signed(yaw_rate)));
				check_value("pitch_rate", exp_rate[2], int'($signed(pitch_rate)));
				check_value("roll_rate", exp_rate[3], int'($signed(roll_rate)));
				check_value("pitch_angle_error", exp_err[0], int'($signed(pitch_angle_error)));
				check_value("roll_angle_error", exp_err[1], int'($signed(roll_angle_error)));
			end
			if (motors_valid) begin
				valid_edge = cycle;
				seen_valid = 1'b1;
				check_motors(exp_motor[0], exp_motor[1], exp_motor[2], exp_motor[3]);
			end else begin
				// previous commands hold until the new pulse
				check_motors(prev[0], prev[1], prev[2], prev[3]);
			end
			// always a strobe while start is pending, random ones while busy
			randomize_inputs(!seen_valid && (cycle == strobe_edge || ($random(seed) & 1) != 0));
		end
		check_true(done_edge - strobe_edge == 4, $sformatf(
			"rates_done came %0d cycles after the strobe instead of 4", done_edge - strobe_edge));
		check_true(valid_edge - strobe_edge == 5, $sformatf(
			"motors_valid came %0d cycles after the strobe instead of 5", valid_edge - strobe_edge));
		@(negedge us_clk);
		check_true(!motors_valid, "motors_valid pulsed again with no accepted strobe");
		check_motors(exp_motor[0], exp_motor[1], exp_motor[2], exp_motor[3]);
		randomize_inputs(1'b0);
		report_test($sformatf("sample %0d", idx));
	endtask

	initial begin
		sample_strobe = 1'b0;
		throttle_target = '0;
		yaw_target = '0;
		pitch_target = '0;
		roll_target = '0;
		pitch_actual = '0;
		roll_actual = '0;
		wait (resetn === 1'b1);
		@(negedge us_clk);
		check_true(!busy && !rates_done && !motors_valid, "a control output was high after reset");
		check_motors(0, 0, 0, 0);
		report_test("reset");
		for (int i = 0; i < NUM_SAMPLES; i++) begin
			run_sample(i);
		end
		$display("tests: %0d, passed: %0d, failed: %0d, errors: %0d",
			tests_passed + tests_failed, tests_passed, tests_failed, total_errors);
		if (total_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// each sample takes eight cycles, the rest covers reset
	initial begin
		#((NUM_SAMPLES * 8 + 50) * CLK_PERIOD);
		$display("timeout: the run did not finish within %0d clock periods",
			NUM_SAMPLES * 8 + 50);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
flight_pkg.sv
target_capture.sv
angle_controller.sv
motor_mixer.sv
flight_ctrl_top.sv
tb_clock.sv
flight_ctrl_properties.sv
flight_ctrl_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= flight_ctrl_tb
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert --timescale 1ns/1ps
PASS_MSG ?= === PASS ===

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the run passes only if the pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
